//--- Makefile
VERILATOR ?= verilator
TOP       ?= riscv_core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module decode_stage (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         stall_d,
	input  logic                         flush_d,
	input  logic [`RV_XLEN-1:0]          pc_f,
	input  logic [`RV_XLEN-1:0]          pc_plus4_f,
	input  logic [`RV_XLEN-1:0]          instr_f,
	output logic [`RV_XLEN-1:0]          pc_d,
	output logic [`RV_XLEN-1:0]          pc_plus4_d,
	output logic [`RV_XLEN-1:0]          imm_d,
	output logic [`RV_REG_AW-1:0]        rs1_d,
	output logic [`RV_REG_AW-1:0]        rs2_d,
	output logic [`RV_REG_AW-1:0]        rd_d,
	output logic                         reg_write_d,
	output logic                         mem_write_d,
	output logic                         branch_d,
	output logic                         jump_d,
	output logic                         alu_src_d,
	output riscv_pkg::result_src_t       result_src_d,
	output riscv_pkg::alu_op_t           alu_op_d
);

	logic [`RV_XLEN-1:0]  instr_d;
	riscv_pkg::imm_src_t  imm_src;

	// An all-zero word is an unknown opcode and acts as the bubble
	always_ff @(posedge clk) begin
		if (rst || flush_d) begin
			instr_d <= '0;
		end else if (!stall_d) begin
			instr_d <= instr_f;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_d) begin
			pc_d       <= pc_f;
			pc_plus4_d <= pc_plus4_f;
		end
	end

	assign rs1_d = instr_d[19:15];
	assign rs2_d = instr_d[24:20];
	assign rd_d  = instr_d[11:7];

	always_comb begin
		reg_write_d  = 1'b0;
		mem_write_d  = 1'b0;
		branch_d     = 1'b0;
		jump_d       = 1'b0;
		alu_src_d    = 1'b0;
		result_src_d = riscv_pkg::RES_ALU;
		alu_op_d     = riscv_pkg::ALU_ADD;
		imm_src      = riscv_pkg::IMM_I;
		case (riscv_pkg::opcode_t'(instr_d[6:0]))
			riscv_pkg::OP_LW: begin
				reg_write_d  = 1'b1;
				alu_src_d    = 1'b1;
				result_src_d = riscv_pkg::RES_MEM;
			end
			riscv_pkg::OP_SW: begin
				mem_write_d = 1'b1;
				alu_src_d   = 1'b1;
				imm_src     = riscv_pkg::IMM_S;
			end
			riscv_pkg::OP_R: begin
				reg_write_d = 1'b1;
				case (instr_d[14:12])
					3'b000:  alu_op_d = instr_d[30] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
					3'b010:  alu_op_d = riscv_pkg::ALU_SLT;
					3'b110:  alu_op_d = riscv_pkg::ALU_OR;
					3'b111:  alu_op_d = riscv_pkg::ALU_AND;
					default: alu_op_d = riscv_pkg::ALU_ADD;
				endcase
			end
			riscv_pkg::OP_I: begin // addi only
				reg_write_d = 1'b1;
				alu_src_d   = 1'b1;
			end
			riscv_pkg::OP_BEQ: begin
				branch_d = 1'b1;
				alu_op_d = riscv_pkg::ALU_SUB;
				imm_src  = riscv_pkg::IMM_B;
			end
			riscv_pkg::OP_JAL: begin
				reg_write_d  = 1'b1;
				jump_d       = 1'b1;
				result_src_d = riscv_pkg::RES_PC4;
				imm_src      = riscv_pkg::IMM_J;
			end
			default: ; // No write, no store, no redirect
		endcase
	end

	// Sign-extended immediates
	always_comb begin
		case (imm_src)
			riscv_pkg::IMM_S: imm_d = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
			riscv_pkg::IMM_B: imm_d = {{20{instr_d[31]}}, instr_d[7], instr_d[30:25],
				instr_d[11:8], 1'b0};
			riscv_pkg::IMM_J: imm_d = {{12{instr_d[31]}}, instr_d[19:12], instr_d[20],
				instr_d[30:21], 1'b0};
			default:          imm_d = {{20{instr_d[31]}}, instr_d[31:20]};
		endcase
	end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module execute_stage (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         flush_e,
	input  logic [`RV_XLEN-1:0]          pc_d,
	input  logic [`RV_XLEN-1:0]          pc_plus4_d,
	input  logic [`RV_XLEN-1:0]          imm_d,
	input  logic [`RV_REG_AW-1:0]        rs1_d,
	input  logic [`RV_REG_AW-1:0]        rs2_d,
	input  logic [`RV_REG_AW-1:0]        rd_d,
	input  logic                         reg_write_d,
	input  logic                         mem_write_d,
	input  logic                         branch_d,
	input  logic                         jump_d,
	input  logic                         alu_src_d,
	input  riscv_pkg::result_src_t       result_src_d,
	input  riscv_pkg::alu_op_t           alu_op_d,
	input  logic [`RV_XLEN-1:0]          rd1_d,
	input  logic [`RV_XLEN-1:0]          rd2_d,
	input  riscv_pkg::fwd_sel_t          fwd_a,
	input  riscv_pkg::fwd_sel_t          fwd_b,
	input  logic [`RV_XLEN-1:0]          alu_result_m,
	input  logic [`RV_XLEN-1:0]          result_w,
	output logic [`RV_REG_AW-1:0]        rs1_e,
	output logic [`RV_REG_AW-1:0]        rs2_e,
	output logic [`RV_REG_AW-1:0]        rd_e,
	output logic                         reg_write_e,
	output logic                         mem_write_e,
	output logic                         is_load_e,
	output riscv_pkg::result_src_t       result_src_e,
	output logic [`RV_XLEN-1:0]          alu_result_e,
	output logic [`RV_XLEN-1:0]          store_data_e,
	output logic [`RV_XLEN-1:0]          pc_plus4_e,
	output logic                         redirect,
	output logic [`RV_XLEN-1:0]          target
);

	logic                 branch_e;
	logic                 jump_e;
	logic                 alu_src_e;
	riscv_pkg::alu_op_t   alu_op_e;
	logic [`RV_XLEN-1:0]  pc_e;
	logic [`RV_XLEN-1:0]  imm_e;
	logic [`RV_XLEN-1:0]  rd1_e;
	logic [`RV_XLEN-1:0]  rd2_e;
	logic [`RV_XLEN-1:0]  src_a;
	logic [`RV_XLEN-1:0]  src_b;

	// Control half, cleared to a bubble
	always_ff @(posedge clk) begin
		if (rst || flush_e) begin
			reg_write_e  <= 1'b0;
			mem_write_e  <= 1'b0;
			branch_e     <= 1'b0;
			jump_e       <= 1'b0;
			result_src_e <= riscv_pkg::RES_ALU;
			rs1_e        <= '0;
			rs2_e        <= '0;
			rd_e         <= '0;
		end else begin
			reg_write_e  <= reg_write_d;
			mem_write_e  <= mem_write_d;
			branch_e     <= branch_d;
			jump_e       <= jump_d;
			result_src_e <= result_src_d;
			rs1_e        <= rs1_d;
			rs2_e        <= rs2_d;
			rd_e         <= rd_d;
		end
	end

	always_ff @(posedge clk) begin
		alu_src_e  <= alu_src_d;
		alu_op_e   <= alu_op_d;
		pc_e       <= pc_d;
		pc_plus4_e <= pc_plus4_d;
		imm_e      <= imm_d;
		rd1_e      <= rd1_d;
		rd2_e      <= rd2_d;
	end

	assign is_load_e = (result_src_e == riscv_pkg::RES_MEM);

	always_comb begin
		case (fwd_a)
			riscv_pkg::FWD_MEM: src_a = alu_result_m;
			riscv_pkg::FWD_WB:  src_a = result_w;
			default:            src_a = rd1_e;
		endcase
		case (fwd_b)
			riscv_pkg::FWD_MEM: store_data_e = alu_result_m;
			riscv_pkg::FWD_WB:  store_data_e = result_w;
			default:            store_data_e = rd2_e;
		endcase
	end

	assign src_b = alu_src_e ? imm_e : store_data_e;

	always_comb begin
		case (alu_op_e)
			riscv_pkg::ALU_SUB: alu_result_e = src_a - src_b;
			riscv_pkg::ALU_AND: alu_result_e = src_a & src_b;
			riscv_pkg::ALU_OR:  alu_result_e = src_a | src_b;
			riscv_pkg::ALU_SLT: alu_result_e = {{(`RV_XLEN-1){1'b0}},
				$signed(src_a) < $signed(src_b)};
			default:            alu_result_e = src_a + src_b;
		endcase
	end

	assign target   = pc_e + imm_e;
	assign redirect = jump_e || (branch_e && src_a == store_data_e); // beq compares forwarded rs2

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module fetch_stage (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               stall_f,
	input  logic                               redirect,
	input  logic [`RV_XLEN-1:0]                target,
	input  logic                               imem_we,
	input  logic [$clog2(`RV_IMEM_DEPTH)-1:0]  imem_addr,
	input  logic [`RV_XLEN-1:0]                imem_wdata,
	output logic [`RV_XLEN-1:0]                pc_f,
	output logic [`RV_XLEN-1:0]                pc_plus4_f,
	output logic [`RV_XLEN-1:0]                instr_f
);

	localparam int IMEM_AW = $clog2(`RV_IMEM_DEPTH);

	logic [`RV_XLEN-1:0] imem [0:`RV_IMEM_DEPTH-1];

	assign pc_plus4_f = pc_f + `RV_XLEN'd4;

	// Redirect wins over the load-use stall
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_f <= '0;
		end else if (redirect) begin
			pc_f <= target;
		end else if (!stall_f) begin
			pc_f <= pc_plus4_f;
		end
	end

	// Program load, only while the core is held in reset
	always_ff @(posedge clk) begin
		if (rst && imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	assign instr_f = imem[pc_f[IMEM_AW+1:2]]; // Word index

endmodule

`default_nettype wire

//--- files.f
+incdir+.
riscv_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
riscv_core.sv
riscv_core_assert.sv
riscv_core_tb.sv

//--- hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module hazard_unit (
	input  logic [`RV_REG_AW-1:0] rs1_d,
	input  logic [`RV_REG_AW-1:0] rs2_d,
	input  logic [`RV_REG_AW-1:0] rs1_e,
	input  logic [`RV_REG_AW-1:0] rs2_e,
	input  logic [`RV_REG_AW-1:0] rd_e,
	input  logic [`RV_REG_AW-1:0] rd_m,
	input  logic [`RV_REG_AW-1:0] rd_w,
	input  logic                  is_load_e,
	input  logic                  reg_write_m,
	input  logic                  reg_write_w,
	input  logic                  redirect,
	output logic                  stall_f,
	output logic                  stall_d,
	output logic                  flush_d,
	output logic                  flush_e,
	output riscv_pkg::fwd_sel_t   fwd_a,
	output riscv_pkg::fwd_sel_t   fwd_b
);

	logic load_use;

	// Youngest producer wins, x0 is never forwarded
	function automatic riscv_pkg::fwd_sel_t pick_fwd(input logic [`RV_REG_AW-1:0] rs);
		if (rs != '0 && reg_write_m && rd_m == rs) begin
			return riscv_pkg::FWD_MEM;
		end else if (rs != '0 && reg_write_w && rd_w == rs) begin
			return riscv_pkg::FWD_WB;
		end
		return riscv_pkg::FWD_RF;
	endfunction

	always_comb begin
		fwd_a = pick_fwd(rs1_e);
		fwd_b = pick_fwd(rs2_e);
	end

	assign load_use = is_load_e && rd_e != '0 && (rd_e == rs1_d || rd_e == rs2_d);

	assign stall_f = load_use;
	assign stall_d = load_use;
	assign flush_d = redirect;            // Drops the instruction in decode
	assign flush_e = load_use || redirect;

endmodule

`default_nettype wire

//--- memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module memory_stage (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         reg_write_e,
	input  logic                         mem_write_e,
	input  riscv_pkg::result_src_t       result_src_e,
	input  logic [`RV_REG_AW-1:0]        rd_e,
	input  logic [`RV_XLEN-1:0]          alu_result_e,
	input  logic [`RV_XLEN-1:0]          store_data_e,
	input  logic [`RV_XLEN-1:0]          pc_plus4_e,
	output logic [`RV_REG_AW-1:0]        rd_m,
	output logic                         reg_write_m,
	output logic [`RV_XLEN-1:0]          alu_result_m,
	output logic                         wb_valid,
	output logic [`RV_REG_AW-1:0]        wb_rd,
	output logic [`RV_XLEN-1:0]          wb_data,
	output logic                         st_valid,
	output logic [`RV_XLEN-1:0]          st_addr,
	output logic [`RV_XLEN-1:0]          st_data
);

	localparam int DMEM_AW = $clog2(`RV_DMEM_DEPTH);

	logic                    mem_write_m;
	riscv_pkg::result_src_t  result_src_m;
	riscv_pkg::result_src_t  result_src_w;
	logic [`RV_XLEN-1:0]     store_data_m;
	logic [`RV_XLEN-1:0]     pc_plus4_m;
	logic [`RV_XLEN-1:0]     read_data_m;
	logic [`RV_XLEN-1:0]     alu_result_w;
	logic [`RV_XLEN-1:0]     read_data_w;
	logic [`RV_XLEN-1:0]     pc_plus4_w;
	logic [`RV_XLEN-1:0]     dmem [0:`RV_DMEM_DEPTH-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_write_m <= 1'b0;
			mem_write_m <= 1'b0;
			wb_valid    <= 1'b0; // Write enable of the writeback stage
		end else begin
			reg_write_m <= reg_write_e;
			mem_write_m <= mem_write_e;
			wb_valid    <= reg_write_m;
		end
	end

	always_ff @(posedge clk) begin
		result_src_m <= result_src_e;
		rd_m         <= rd_e;
		alu_result_m <= alu_result_e;
		store_data_m <= store_data_e;
		pc_plus4_m   <= pc_plus4_e;
		result_src_w <= result_src_m;
		wb_rd        <= rd_m;
		alu_result_w <= alu_result_m;
		read_data_w  <= read_data_m;
		pc_plus4_w   <= pc_plus4_m;
	end

	// Word memory, address bits [1:0] ignored
	always_ff @(posedge clk) begin
		if (mem_write_m) begin
			dmem[alu_result_m[DMEM_AW+1:2]] <= store_data_m;
		end
	end

	assign read_data_m = dmem[alu_result_m[DMEM_AW+1:2]];

	assign st_valid = mem_write_m;
	assign st_addr  = alu_result_m;
	assign st_data  = store_data_m;

	always_comb begin
		case (result_src_w)
			riscv_pkg::RES_MEM: wb_data = read_data_w;
			riscv_pkg::RES_PC4: wb_data = pc_plus4_w;
			default:            wb_data = alu_result_w;
		endcase
	end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module register_file (
	input  logic                  clk,
	input  logic [`RV_REG_AW-1:0] rs1,
	input  logic [`RV_REG_AW-1:0] rs2,
	input  logic [`RV_REG_AW-1:0] rd,
	input  logic                  we,
	input  logic [`RV_XLEN-1:0]   wd,
	output logic [`RV_XLEN-1:0]   rd1,
	output logic [`RV_XLEN-1:0]   rd2
);

	logic [`RV_XLEN-1:0] regs [0:(1<<`RV_REG_AW)-1];

	always_ff @(posedge clk) begin
		if (we && rd != '0) begin
			regs[rd] <= wd; // x0 stays zero
		end
	end

	// Same-cycle write is seen by the reader
	assign rd1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

endmodule

`default_nettype wire

//--- riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_core (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               imem_we,
	input  logic [$clog2(`RV_IMEM_DEPTH)-1:0]  imem_addr,
	input  logic [`RV_XLEN-1:0]                imem_wdata,
	output logic                               wb_valid,
	output logic [`RV_REG_AW-1:0]              wb_rd,
	output logic [`RV_XLEN-1:0]                wb_data,
	output logic                               st_valid,
	output logic [`RV_XLEN-1:0]                st_addr,
	output logic [`RV_XLEN-1:0]                st_data
);

	// Fetch
	logic [`RV_XLEN-1:0]     pc_f, pc_plus4_f, instr_f;
	// Decode
	logic [`RV_XLEN-1:0]     pc_d, pc_plus4_d, imm_d, rd1_d, rd2_d;
	logic [`RV_REG_AW-1:0]   rs1_d, rs2_d, rd_d;
	logic                    reg_write_d, mem_write_d, branch_d, jump_d, alu_src_d;
	riscv_pkg::result_src_t  result_src_d;
	riscv_pkg::alu_op_t      alu_op_d;
	// Execute
	logic [`RV_REG_AW-1:0]   rs1_e, rs2_e, rd_e;
	logic                    reg_write_e, mem_write_e, is_load_e, redirect;
	riscv_pkg::result_src_t  result_src_e;
	logic [`RV_XLEN-1:0]     alu_result_e, store_data_e, pc_plus4_e, target;
	// Memory and hazards
	logic [`RV_REG_AW-1:0]   rd_m;
	logic                    reg_write_m;
	logic [`RV_XLEN-1:0]     alu_result_m;
	logic                    stall_f, stall_d, flush_d, flush_e;
	riscv_pkg::fwd_sel_t     fwd_a, fwd_b;

	fetch_stage i_fetch_stage (
		.clk, .rst, .stall_f, .redirect, .target,
		.imem_we, .imem_addr, .imem_wdata,
		.pc_f, .pc_plus4_f, .instr_f
	);

	decode_stage i_decode_stage (
		.clk, .rst, .stall_d, .flush_d, .pc_f, .pc_plus4_f, .instr_f,
		.pc_d, .pc_plus4_d, .imm_d, .rs1_d, .rs2_d, .rd_d,
		.reg_write_d, .mem_write_d, .branch_d, .jump_d, .alu_src_d,
		.result_src_d, .alu_op_d
	);

	register_file i_register_file (
		.clk, .rs1(rs1_d), .rs2(rs2_d), .rd(wb_rd), .we(wb_valid), .wd(wb_data),
		.rd1(rd1_d), .rd2(rd2_d)
	);

	execute_stage i_execute_stage (
		.clk, .rst, .flush_e, .pc_d, .pc_plus4_d, .imm_d, .rs1_d, .rs2_d, .rd_d,
		.reg_write_d, .mem_write_d, .branch_d, .jump_d, .alu_src_d,
		.result_src_d, .alu_op_d, .rd1_d, .rd2_d, .fwd_a, .fwd_b,
		.alu_result_m, .result_w(wb_data),
		.rs1_e, .rs2_e, .rd_e, .reg_write_e, .mem_write_e, .is_load_e,
		.result_src_e, .alu_result_e, .store_data_e, .pc_plus4_e, .redirect, .target
	);

	memory_stage i_memory_stage (
		.clk, .rst, .reg_write_e, .mem_write_e, .result_src_e, .rd_e,
		.alu_result_e, .store_data_e, .pc_plus4_e,
		.rd_m, .reg_write_m, .alu_result_m,
		.wb_valid, .wb_rd, .wb_data, .st_valid, .st_addr, .st_data
	);

	hazard_unit i_hazard_unit (
		.rs1_d, .rs2_d, .rs1_e, .rs2_e, .rd_e, .rd_m, .rd_w(wb_rd),
		.is_load_e, .reg_write_m, .reg_write_w(wb_valid), .redirect,
		.stall_f, .stall_d, .flush_d, .flush_e, .fwd_a, .fwd_b
	);

endmodule

`default_nettype wire

//--- riscv_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_core_assert (
	input logic                clk,
	input logic                rst,
	input logic                imem_we,
	input logic                wb_valid,
	input logic                st_valid,
	input logic [`RV_XLEN-1:0] st_addr
);

	logic rst_q; // Reset seen on the previous edge

	always_ff @(posedge clk) begin
		rst_q <= rst;
	end

	// Stage registers are clear once reset has been held for one edge
	no_strobe_in_reset: assert property (@(posedge clk) (rst && rst_q) |-> (!wb_valid && !st_valid))
		else $error("writeback or store strobe while reset is held");

	load_only_in_reset: assert property (@(posedge clk) imem_we |-> rst)
		else $error("instruction memory written outside reset");

	store_aligned: assert property (@(posedge clk) st_valid |-> (st_addr[1:0] == 2'b00))
		else $error("store address 0x%08h is not word aligned", st_addr);

endmodule

bind riscv_core riscv_core_assert i_riscv_core_assert (
	.clk, .rst, .imem_we, .wb_valid, .st_valid, .st_addr
);

`default_nettype wire

//--- riscv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_core_tb;

	localparam int IMEM_AW        = $clog2(`RV_IMEM_DEPTH);
	localparam int RESET_CYCLES   = 3;
	localparam int BUDGET         = 40; // Collection window per test
	localparam int MAX_PROG       = 16;
	localparam int TIMEOUT_CYCLES = 4 * (1 + RESET_CYCLES + MAX_PROG + BUDGET) + 100;

	logic                  clk;
	logic                  rst;
	logic                  imem_we;
	logic [IMEM_AW-1:0]    imem_addr;
	logic [`RV_XLEN-1:0]   imem_wdata;
	logic                  wb_valid;
	logic [`RV_REG_AW-1:0] wb_rd;
	logic [`RV_XLEN-1:0]   wb_data;
	logic                  st_valid;
	logic [`RV_XLEN-1:0]   st_addr;
	logic [`RV_XLEN-1:0]   st_data;

	logic [`RV_XLEN-1:0]   prog [$];
	logic [`RV_REG_AW-1:0] got_rd [$];
	logic [`RV_XLEN-1:0]   got_wd [$];
	logic [`RV_REG_AW-1:0] exp_rd [$];
	logic [`RV_XLEN-1:0]   exp_wd [$];
	logic [`RV_XLEN-1:0]   got_sa [$];
	logic [`RV_XLEN-1:0]   got_sd [$];
	logic [`RV_XLEN-1:0]   exp_sa [$];
	logic [`RV_XLEN-1:0]   exp_sd [$];
	integer                seed;
	int                    wb_errors = 0;
	int                    st_errors = 0;
	int                    other_errors = 0;
	int                    cycle_count = 0;

	riscv_core i_riscv_core (
		.clk, .rst, .imem_we, .imem_addr, .imem_wdata,
		.wb_valid, .wb_rd, .wb_data, .st_valid, .st_addr, .st_data
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// RV32I encodings
	function automatic logic [31:0] rtype_insn(input logic [6:0] funct7,
		input logic [2:0] funct3, input logic [4:0] rd, rs1, rs2);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] addi_insn(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lw_insn(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] sw_insn(input logic [4:0] rs2, rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] beq_insn(input logic [4:0] rs1, rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_insn(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [`RV_XLEN-1:0] sext12(input logic [11:0] v);
		return {{(`RV_XLEN-12){v[11]}}, v};
	endfunction

	task automatic expect_wb(input logic [`RV_REG_AW-1:0] rd, input logic [`RV_XLEN-1:0] data);
		exp_rd.push_back(rd);
		exp_wd.push_back(data);
	endtask

	task automatic expect_store(input logic [`RV_XLEN-1:0] addr, input logic [`RV_XLEN-1:0] data);
		exp_sa.push_back(addr);
		exp_sd.push_back(data);
	endtask

	task automatic clear_lists();
		prog.delete();
		got_rd.delete();
		got_wd.delete();
		exp_rd.delete();
		exp_wd.delete();
		got_sa.delete();
		got_sd.delete();
		exp_sa.delete();
		exp_sd.delete();
	endtask

	// Reset, load, release, then gather strobes for a fixed window
	task automatic run_program(input int budget);
		@(negedge clk);
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		prog.push_back(beq_insn(5'd0, 5'd0, 13'd0)); // Halt loop
		for (int i = 0; i < prog.size(); i++) begin
			imem_we    = 1'b1;
			imem_addr  = IMEM_AW'(i);
			imem_wdata = prog[i];
			@(negedge clk);
			if (wb_valid || st_valid) begin
				other_errors++;
				$display("A strobe appeared at %0t while reset was held", $time);
			end
		end
		imem_we = 1'b0;
		rst     = 1'b0;
		repeat (budget) begin
			@(negedge clk);
			if (wb_valid) begin
				got_rd.push_back(wb_rd);
				got_wd.push_back(wb_data);
			end
			if (st_valid) begin
				got_sa.push_back(st_addr);
				got_sd.push_back(st_data);
			end
		end
	endtask

	task automatic check_wb(input logic [`RV_REG_AW-1:0] got_r, input logic [`RV_XLEN-1:0] got_d,
		input logic [`RV_REG_AW-1:0] want_r, input logic [`RV_XLEN-1:0] want_d);
		if (got_r !== want_r) begin
			wb_errors++;
			$display("FAILED at %0t: wb_rd is %0d, expected %0d", $time, got_r, want_r);
		end
		if (got_d !== want_d) begin
			wb_errors++;
			$display("FAILED at %0t: wb_data is 0x%08h, expected 0x%08h", $time, got_d, want_d);
		end
	endtask

	task automatic check_store(input logic [`RV_XLEN-1:0] got_a, input logic [`RV_XLEN-1:0] got_d,
		input logic [`RV_XLEN-1:0] want_a, input logic [`RV_XLEN-1:0] want_d);
		if (got_a !== want_a) begin
			st_errors++;
			$display("FAILED at %0t: st_addr is 0x%08h, expected 0x%08h", $time, got_a, want_a);
		end
		if (got_d !== want_d) begin
			st_errors++;
			$display("FAILED at %0t: st_data is 0x%08h, expected 0x%08h", $time, got_d, want_d);
		end
	endtask

	task automatic check_count(input string name, input string kind, input int got, input int want);
		if (got < want) begin
			other_errors++;
			$display("%s: %0d %s strobes are missing, saw %0d of %0d", name, want - got, kind,
				got, want);
		end else if (got > want) begin
			other_errors++;
			$display("%s: %0d extra %s strobes, saw %0d of %0d", name, got - want, kind, got, want);
		end
	endtask

	task automatic compare_results(input string name);
		int n;
		check_count(name, "writeback", got_rd.size(), exp_rd.size());
		n = (got_rd.size() < exp_rd.size()) ? got_rd.size() : exp_rd.size();
		for (int i = 0; i < n; i++) begin
			check_wb(got_rd[i], got_wd[i], exp_rd[i], exp_wd[i]);
		end
		check_count(name, "store", got_sa.size(), exp_sa.size());
		n = (got_sa.size() < exp_sa.size()) ? got_sa.size() : exp_sa.size();
		for (int i = 0; i < n; i++) begin
			check_store(got_sa[i], got_sd[i], exp_sa[i], exp_sd[i]);
		end
	endtask

	// Back-to-back dependent ALU ops, forwarded from memory and writeback
	task automatic alu_chain();
		logic [31:0]         r;
		logic [11:0]         ia;
		logic [11:0]         ib;
		logic [`RV_XLEN-1:0] x1;
		logic [`RV_XLEN-1:0] x2;
		logic [`RV_XLEN-1:0] x3;
		logic [`RV_XLEN-1:0] x4;
		logic [`RV_XLEN-1:0] x5;
		clear_lists();
		r  = $random(seed);
		ia = r[11:0];
		r  = $random(seed);
		ib = r[11:0];
		x1 = sext12(ia);
		x2 = x1 + sext12(ib);
		x3 = x1 + x2;
		x4 = x1 - x3;
		x5 = x4 & x2;
		prog.push_back(addi_insn(5'd1, 5'd0, ia));
		prog.push_back(addi_insn(5'd2, 5'd1, ib));
		prog.push_back(rtype_insn(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2)); // add
		prog.push_back(rtype_insn(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd3)); // sub
		prog.push_back(rtype_insn(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd2)); // and
		prog.push_back(rtype_insn(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd3)); // or
		prog.push_back(rtype_insn(7'b0000000, 3'b010, 5'd7, 5'd4, 5'd3)); // slt
		prog.push_back(rtype_insn(7'b0000000, 3'b010, 5'd8, 5'd3, 5'd4));
		expect_wb(5'd1, x1);
		expect_wb(5'd2, x2);
		expect_wb(5'd3, x3);
		expect_wb(5'd4, x4);
		expect_wb(5'd5, x5);
		expect_wb(5'd6, x5 | x3);
		expect_wb(5'd7, ($signed(x4) < $signed(x3)) ? 32'd1 : 32'd0);
		expect_wb(5'd8, ($signed(x3) < $signed(x4)) ? 32'd1 : 32'd0);
		run_program(BUDGET);
		compare_results("alu chain");
	endtask

	task automatic load_use();
		logic [`RV_XLEN-1:0] val;
		clear_lists();
		val = sext12(12'hedd);
		prog.push_back(addi_insn(5'd1, 5'd0, 12'h040)); // Base address
		prog.push_back(addi_insn(5'd2, 5'd0, 12'hedd));
		prog.push_back(sw_insn(5'd2, 5'd1, 12'd8));
		prog.push_back(lw_insn(5'd3, 5'd1, 12'd8));
		prog.push_back(rtype_insn(7'b0000000, 3'b000, 5'd4, 5'd3, 5'd2)); // Stalls one cycle
		prog.push_back(sw_insn(5'd4, 5'd1, 12'd12));
		expect_wb(5'd1, 32'h40);
		expect_wb(5'd2, val);
		expect_store(32'h48, val);
		expect_wb(5'd3, val);
		expect_wb(5'd4, val + val);
		expect_store(32'h4c, val + val);
		run_program(BUDGET);
		compare_results("load use");
	endtask

	// Taken beq drops an addi and a sw, the not-taken one lets both retire
	task automatic branch_flush();
		clear_lists();
		prog.push_back(addi_insn(5'd1, 5'd0, 12'd5));
		prog.push_back(addi_insn(5'd2, 5'd0, 12'd5));
		prog.push_back(beq_insn(5'd1, 5'd2, 13'd16));
		prog.push_back(addi_insn(5'd3, 5'd0, 12'd1));
		prog.push_back(sw_insn(5'd1, 5'd0, 12'd0));
		prog.push_back(addi_insn(5'd4, 5'd0, 12'd2));  // Never fetched
		prog.push_back(addi_insn(5'd5, 5'd0, 12'd3));  // Branch target
		prog.push_back(beq_insn(5'd1, 5'd0, 13'd12));
		prog.push_back(addi_insn(5'd6, 5'd0, 12'd4));
		prog.push_back(sw_insn(5'd6, 5'd0, 12'd4));
		expect_wb(5'd1, 32'd5);
		expect_wb(5'd2, 32'd5);
		expect_wb(5'd5, 32'd3);
		expect_wb(5'd6, 32'd4);
		expect_store(32'd4, 32'd4);
		run_program(BUDGET);
		compare_results("branch flush");
	endtask

	task automatic jump_and_x0();
		clear_lists();
		prog.push_back(addi_insn(5'd1, 5'd0, 12'd7));
		prog.push_back(jal_insn(5'd5, 21'd16));        // pc 4 to 20
		prog.push_back(addi_insn(5'd1, 5'd0, 12'd99));
		prog.push_back(sw_insn(5'd1, 5'd0, 12'd0));
		prog.push_back(addi_insn(5'd2, 5'd0, 12'd55)); // Never fetched
		prog.push_back(rtype_insn(7'b0000000, 3'b000, 5'd6, 5'd5, 5'd1));
		prog.push_back(addi_insn(5'd0, 5'd0, 12'd123)); // Reported, not kept
		prog.push_back(rtype_insn(7'b0000000, 3'b000, 5'd7, 5'd0, 5'd0));
		expect_wb(5'd1, 32'd7);
		expect_wb(5'd5, 32'd8);
		expect_wb(5'd6, 32'd15);
		expect_wb(5'd0, 32'd123);
		expect_wb(5'd7, 32'd0);
		run_program(BUDGET);
		compare_results("jump and x0");
	endtask

	initial begin
		rst        = 1'b1;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		seed       = 32'h16e1267e;
		alu_chain();
		load_use();
		branch_flush();
		jump_and_x0();
		$display("Errors: writeback %0d, store %0d, other %0d", wb_errors, st_errors, other_errors);
		if (wb_errors + st_errors + other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// Data path and address width
`define RV_XLEN 32

// Register index width
`define RV_REG_AW 5

// Memory sizes in words
`define RV_IMEM_DEPTH 64
`define RV_DMEM_DEPTH 64

`endif

//--- riscv_pkg.sv
`default_nettype none

package riscv_pkg;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_LW  = 7'b0000011,
		OP_SW  = 7'b0100011,
		OP_R   = 7'b0110011,
		OP_I   = 7'b0010011,
		OP_BEQ = 7'b1100011,
		OP_JAL = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_t;

	typedef enum logic [1:0] {
		IMM_I = 2'd0,
		IMM_S = 2'd1,
		IMM_B = 2'd2,
		IMM_J = 2'd3
	} imm_src_t;

	typedef enum logic [1:0] {
		RES_ALU = 2'd0, // ALU result
		RES_MEM = 2'd1, // Load data
		RES_PC4 = 2'd2  // Link address
	} result_src_t;

	typedef enum logic [1:0] {
		FWD_RF  = 2'd0,
		FWD_WB  = 2'd1,
		FWD_MEM = 2'd2
	} fwd_sel_t;

endpackage

`default_nettype wire
